//--- hw/pose_pkg.sv
`default_nettype none

package pose_pkg;

  // coordinate widths, sized for the 320x180 binned frame
  localparam int coord_w_x = 9;  // 0..319
  localparam int coord_w_y = 8;  // 0..179

  // match count width
  localparam int score_w = 16;

  // one beat of the binned skeleton stream
  // no ready, the back end never stalls
  typedef struct packed {
    logic                 valid;
    logic [coord_w_x-1:0] hcount;
    logic [coord_w_y-1:0] vcount;
    logic                 pixel;  // skeleton bit
  } pix_beat_t;

  // centre of mass of one frame, in binned coordinates
  typedef struct packed {
    logic [coord_w_x-1:0] x;
    logic [coord_w_y-1:0] y;
  } com_t;

endpackage

`default_nettype wire

//--- hw/reference_ctrl.sv
`default_nettype none

module reference_ctrl #(
  parameter int FRAME_W = 320,
  parameter int FRAME_H = 180
) (
  input  wire                 clk_pixel,
  input  wire                 sys_rst_pixel,
  input  pose_pkg::pix_beat_t beat_i,
  input  wire                 capture_req_i,
  output logic                capture_ack_o,
  output logic                storing_o,
  output logic                store_start_o,
  output logic                ref_valid_o
);

  typedef enum logic [1:0] {
    ST_IDLE,   // waiting for a request
    ST_ARMED,  // request seen, waiting for the next frame start
    ST_STORE,  // writing the reference frame
    ST_ACK     // ack high until req drops
  } state_t;

  state_t state_q, state_d;
  logic   first_pix;  // valid beat at (0,0)
  logic   last_pix;   // valid beat at the bottom right corner
  logic   ref_valid_q;

  assign first_pix = beat_i.valid && beat_i.hcount == '0 && beat_i.vcount == '0;
  assign last_pix  = beat_i.valid &&
                     beat_i.hcount == pose_pkg::coord_w_x'(FRAME_W - 1) &&
                     beat_i.vcount == pose_pkg::coord_w_y'(FRAME_H - 1);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:  if (capture_req_i) state_d = ST_ARMED;
      ST_ARMED: if (first_pix) state_d = ST_STORE;  // store starts on this very beat
      ST_STORE: if (last_pix) state_d = ST_ACK;
      ST_ACK:   if (!capture_req_i) state_d = ST_IDLE;  // ack drops next cycle
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) begin
      state_q     <= ST_IDLE;
      ref_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_STORE && last_pix) ref_valid_q <= 1'b1;  // sticky once stored
    end
  end

  assign store_start_o = (state_q == ST_ARMED) && first_pix;
  assign storing_o     = store_start_o || (state_q == ST_STORE);  // covers first..last beat
  assign capture_ack_o = (state_q == ST_ACK);  // rises the cycle after the last stored beat
  assign ref_valid_o   = ref_valid_q;

  // host must hold req through the store, so ack only ever comes up under req
  a_ack_needs_req: assert property (
    @(posedge clk_pixel) disable iff (sys_rst_pixel)
    $rose(capture_ack_o) |-> capture_req_i
  );

endmodule

`default_nettype wire

//--- hw/com_align.sv
`default_nettype none

module com_align #(
  parameter int FRAME_W = 320,
  parameter int FRAME_H = 180
) (
  input  wire                 clk_pixel,
  input  wire                 sys_rst_pixel,
  input  pose_pkg::pix_beat_t beat_i,
  input  pose_pkg::com_t      com_i,
  input  wire                 com_valid_i,
  input  wire                 store_start_i,
  output pose_pkg::pix_beat_t aligned_o
);

  pose_pkg::com_t      cur_com_q;  // com of the frame now streaming
  pose_pkg::com_t      ref_com_q;  // com of the stored reference
  pose_pkg::pix_beat_t aligned_d;
  pose_pkg::pix_beat_t aligned_q;

  // pos + cur - ref, pinned to 0..lim-1
  function automatic int shift_clamp(int pos, int cur, int ref_c, int lim);
    int d;
    d = pos + cur - ref_c;
    if (d < 0) return 0;
    if (d > lim - 1) return lim - 1;
    return d;
  endfunction

  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) begin
      cur_com_q <= '0;
      ref_com_q <= '0;
    end else begin
      if (com_valid_i) cur_com_q <= com_i;  // arrives ahead of the frame's first beat
      if (store_start_i) ref_com_q <= cur_com_q;  // snapshot for the frame being stored
    end
  end

  always_comb begin
    aligned_d        = beat_i;  // valid and pixel pass straight through
    aligned_d.hcount = pose_pkg::coord_w_x'(shift_clamp(int'(beat_i.hcount),
                         int'(cur_com_q.x), int'(ref_com_q.x), FRAME_W));
    aligned_d.vcount = pose_pkg::coord_w_y'(shift_clamp(int'(beat_i.vcount),
                         int'(cur_com_q.y), int'(ref_com_q.y), FRAME_H));
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) aligned_q <= '0;
    else aligned_q <= aligned_d;  // one register stage
  end

  assign aligned_o = aligned_q;

  // whatever the com difference, the read address stays inside the frame
  a_in_frame: assert property (
    @(posedge clk_pixel) disable iff (sys_rst_pixel)
    beat_i.valid |=> (aligned_o.hcount < FRAME_W && aligned_o.vcount < FRAME_H)
  );

endmodule

`default_nettype wire

//--- hw/reference_buffer.sv
`default_nettype none

module reference_buffer #(
  parameter int FRAME_W = 320,
  parameter int FRAME_H = 180
) (
  input  wire                 clk_pixel,
  input  pose_pkg::pix_beat_t wr_beat_i,  // raw beat, written while storing
  input  wire                 wr_en_i,
  input  pose_pkg::pix_beat_t rd_beat_i,  // aligned beat, shifted coords
  output logic                ref_bit_o
);

  localparam int DEPTH  = FRAME_W * FRAME_H;
  localparam int ADDR_W = $clog2(DEPTH);

  logic              mem [DEPTH];  // one bit per binned pixel
  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd_addr;
  logic              ref_bit_q;

  // row major, same mapping on both ports
  assign wr_addr = ADDR_W'(int'(wr_beat_i.vcount) * FRAME_W + int'(wr_beat_i.hcount));
  assign rd_addr = ADDR_W'(int'(rd_beat_i.vcount) * FRAME_W + int'(rd_beat_i.hcount));

  always_ff @(posedge clk_pixel) begin
    if (wr_en_i && wr_beat_i.valid) mem[wr_addr] <= wr_beat_i.pixel;
  end

  // registered read, read-first against a same cycle write
  always_ff @(posedge clk_pixel) begin
    if (rd_beat_i.valid) ref_bit_q <= mem[rd_addr];
  end

  assign ref_bit_o = ref_bit_q;

endmodule

`default_nettype wire

//--- hw/match_accumulator.sv
`default_nettype none

module match_accumulator #(
  parameter int FRAME_W = 320,
  parameter int FRAME_H = 180,
  parameter int SCORE_W = pose_pkg::score_w
) (
  input  wire                 clk_pixel,
  input  wire                 sys_rst_pixel,
  input  pose_pkg::pix_beat_t beat_i,      // aligned beat
  input  wire                 storing_i,   // level with the raw beat, one stage ahead of beat_i
  input  wire                 ref_valid_i,
  input  wire                 ref_bit_i,   // one stage behind beat_i
  output logic [SCORE_W-1:0]  frame_score_o,
  output logic                frame_done_o
);

  localparam int NPIX  = FRAME_W * FRAME_H;
  localparam int POS_W = $clog2(NPIX);

  logic               vld_q;      // aligned beat delayed onto ref_bit_i
  logic               pix_q;
  logic [1:0]         store_q;    // storing needs two stages to reach the same beat
  logic [POS_W-1:0]   pos_q;      // beat index in the frame
  logic [SCORE_W-1:0] count_q;
  logic [SCORE_W-1:0] sum;
  logic               hit;
  logic               last;

  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) begin
      vld_q   <= 1'b0;
      store_q <= '0;
    end else begin
      vld_q   <= beat_i.valid;
      store_q <= {store_q[0], storing_i};
    end
  end

  always_ff @(posedge clk_pixel) pix_q <= beat_i.pixel;

  // clamped coords can't flag the corner, so frame position comes from the beat count
  assign last = vld_q && pos_q == POS_W'(NPIX - 1);
  assign hit  = vld_q && pix_q && !store_q[1] && ref_valid_i && ref_bit_i;
  assign sum  = (&count_q) ? count_q : count_q + SCORE_W'(hit);  // saturate at all ones

  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) begin
      pos_q   <= '0;
      count_q <= '0;
    end else if (vld_q) begin
      pos_q   <= last ? '0 : pos_q + 1'b1;
      count_q <= last ? '0 : sum;  // fresh count for the next frame
    end
  end

  assign frame_score_o = sum;   // includes the last beat's hit
  assign frame_done_o  = last;

  // frames are far longer than one beat
  a_done_single: assert property (
    @(posedge clk_pixel) disable iff (sys_rst_pixel)
    frame_done_o |=> !frame_done_o
  );

endmodule

`default_nettype wire

//--- hw/score_decimator.sv
`default_nettype none

module score_decimator #(
  parameter int DISPLAY_DIV = 10,
  parameter int SCORE_W     = pose_pkg::score_w
) (
  input  wire                clk_pixel,
  input  wire                sys_rst_pixel,
  input  wire                frame_done_i,
  input  wire  [SCORE_W-1:0] frame_score_i,
  output logic [SCORE_W-1:0] score_o,
  output logic               score_valid_o
);

  localparam int CNT_W = (DISPLAY_DIV > 1) ? $clog2(DISPLAY_DIV) : 1;

  logic [CNT_W-1:0]   div_q;  // frame ends seen, mod DISPLAY_DIV
  logic [SCORE_W-1:0] score_q;
  logic               valid_q;

  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) begin
      div_q   <= '0;
      score_q <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;  // single cycle pulse
      if (frame_done_i) begin
        if (div_q == '0) begin
          score_q <= frame_score_i;  // held until the next shown frame
          valid_q <= 1'b1;
        end
        div_q <= (div_q == CNT_W'(DISPLAY_DIV - 1)) ? '0 : div_q + 1'b1;
      end
    end
  end

  assign score_o       = score_q;
  assign score_valid_o = valid_q;

endmodule

`default_nettype wire

//--- hw/pose_scorer.sv
`default_nettype none

module pose_scorer #(
  parameter int FRAME_W     = 320,
  parameter int FRAME_H     = 180,
  parameter int SCORE_W     = pose_pkg::score_w,
  parameter int DISPLAY_DIV = 10
) (
  input  wire                clk_pixel,
  input  wire                sys_rst_pixel,
  input  pose_pkg::pix_beat_t beat_i,        // binned skeleton stream
  input  pose_pkg::com_t     com_i,          // centre of mass of the coming frame
  input  wire                com_valid_i,
  input  wire                capture_req_i,  // four-phase capture handshake
  output logic               capture_ack_o,
  output logic [SCORE_W-1:0] score_o,
  output logic               score_valid_o
);

  logic                storing;      // level over the store frame beats
  logic                store_start;  // with the accepted (0,0) beat
  logic                ref_valid;    // a reference pose exists
  pose_pkg::pix_beat_t aligned;      // beat with shifted coords, 1 cycle late
  logic                ref_bit;      // reference pixel under aligned, 2 cycles late
  logic [SCORE_W-1:0]  frame_score;
  logic                frame_done;

  reference_ctrl #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) ctrl0 (
    .clk_pixel    (clk_pixel),
    .sys_rst_pixel(sys_rst_pixel),
    .beat_i       (beat_i),
    .capture_req_i(capture_req_i),
    .capture_ack_o(capture_ack_o),
    .storing_o    (storing),
    .store_start_o(store_start),
    .ref_valid_o  (ref_valid)
  );

  com_align #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) align0 (
    .clk_pixel    (clk_pixel),
    .sys_rst_pixel(sys_rst_pixel),
    .beat_i       (beat_i),
    .com_i        (com_i),
    .com_valid_i  (com_valid_i),
    .store_start_i(store_start),
    .aligned_o    (aligned)
  );

  // write with raw coords, read with shifted coords
  reference_buffer #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) refbuf0 (
    .clk_pixel(clk_pixel),
    .wr_beat_i(beat_i),
    .wr_en_i  (storing),
    .rd_beat_i(aligned),
    .ref_bit_o(ref_bit)
  );

  match_accumulator #(
    .FRAME_W(FRAME_W), .FRAME_H(FRAME_H), .SCORE_W(SCORE_W)
  ) acc0 (
    .clk_pixel    (clk_pixel),
    .sys_rst_pixel(sys_rst_pixel),
    .beat_i       (aligned),
    .storing_i    (storing),
    .ref_valid_i  (ref_valid),
    .ref_bit_i    (ref_bit),
    .frame_score_o(frame_score),
    .frame_done_o (frame_done)
  );

  score_decimator #(.DISPLAY_DIV(DISPLAY_DIV), .SCORE_W(SCORE_W)) dec0 (
    .clk_pixel    (clk_pixel),
    .sys_rst_pixel(sys_rst_pixel),
    .frame_done_i (frame_done),
    .frame_score_i(frame_score),
    .score_o      (score_o),
    .score_valid_o(score_valid_o)
  );

endmodule

`default_nettype wire

//--- verification/tb_pose_scorer.sv
`default_nettype none

module tb_pose_scorer;

  localparam int FRAME_W     = 16;
  localparam int FRAME_H     = 8;
  localparam int SCORE_W     = pose_pkg::score_w;
  localparam int DISPLAY_DIV = 3;
  localparam int NPIX        = FRAME_W * FRAME_H;
  localparam int MAX_FRAMES  = 42;            // worst case over all tests, fillers included
  localparam int FRAME_CYC   = NPIX * 4 + 8;  // up to 3 idle cycles per beat, com cycle, tail
  localparam int CYCLE_LIMIT = MAX_FRAMES * FRAME_CYC + 100;

  logic                clk_pixel;
  logic                sys_rst_pixel;
  pose_pkg::pix_beat_t beat_i;
  pose_pkg::com_t      com_i;
  logic                com_valid_i;
  logic                capture_req_i;
  logic                capture_ack_o;
  logic [SCORE_W-1:0]  score_o;
  logic                score_valid_o;

  bit                 cur_pix [NPIX];  // frame about to be sent
  bit                 ref_pix [NPIX];  // model copy of the reference memory
  bit                 ref_ok;
  int                 ref_x;
  int                 ref_y;
  int                 frame_ends;      // frame ends since reset, store frames too
  int                 pulses = 0;      // score_valid_o pulses seen on the DUT
  int                 gap_pct;         // chance of idle cycles ahead of a beat
  int                 cycle_cnt = 0;
  int unsigned        rnd;
  logic [SCORE_W-1:0] held_score;      // what score_o must show between pulses

  pose_scorer #(
    .FRAME_W(FRAME_W), .FRAME_H(FRAME_H), .SCORE_W(SCORE_W), .DISPLAY_DIV(DISPLAY_DIV)
  ) dut0 (
    .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel), .beat_i(beat_i), .com_i(com_i),
    .com_valid_i(com_valid_i), .capture_req_i(capture_req_i), .capture_ack_o(capture_ack_o),
    .score_o(score_o), .score_valid_o(score_valid_o)
  );

  initial begin
    clk_pixel = 1'b0;
    forever #4 clk_pixel = ~clk_pixel;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  always @(posedge clk_pixel) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) fail_run("timeout, the tests ran past their cycle limit");
  end

  // counts what the DUT really shows
  always @(posedge clk_pixel) begin
    if (score_valid_o) pulses <= pulses + 1;
  end

  task automatic compare_score(input string name, input logic [SCORE_W-1:0] got,
                               input logic [SCORE_W-1:0] exp);
    if (got !== exp) fail_run($sformatf("Mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic compare_ack(input string name, input logic got, input logic exp);
    if (got !== exp) fail_run($sformatf("Mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic compare_valid(input string name, input logic got, input logic exp);
    if (got !== exp) fail_run($sformatf("Mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic next_cycle();
    @(posedge clk_pixel);
    #1;  // drive and sample just past the edge
  endtask

  // hits of cur_pix against the reference, shifted by com minus reference com
  function automatic int expected_matches(input int cx, input int cy);
    int n;
    int sx;
    int sy;
    n = 0;
    if (!ref_ok) return 0;  // nothing captured yet
    for (int p = 0; p < NPIX; p++) begin
      sx = p % FRAME_W + cx - ref_x;
      sy = p / FRAME_W + cy - ref_y;
      sx = (sx < 0) ? 0 : (sx > FRAME_W - 1) ? FRAME_W - 1 : sx;
      sy = (sy < 0) ? 0 : (sy > FRAME_H - 1) ? FRAME_H - 1 : sy;
      if (cur_pix[p] && ref_pix[sy * FRAME_W + sx]) n++;
    end
    return (n > 2 ** SCORE_W - 1) ? 2 ** SCORE_W - 1 : n;  // saturating count
  endfunction

  task automatic fill_random();
    for (int p = 0; p < NPIX; p++) cur_pix[p] = ($urandom % 3) == 0;  // about one in three set
  endtask

  task automatic check_quiet();
    compare_ack("capture_ack_o", capture_ack_o, 1'b0);
    compare_valid("score_valid_o", score_valid_o, 1'b0);
    compare_score("score_o", score_o, held_score);
  endtask

  // com cycle, then one full frame, then the tail where the score pulse may land
  task automatic send_frame(input int cx, input int cy, input bit store);
    logic [SCORE_W-1:0] exp_score;
    bit                 shown;
    exp_score   = store ? '0 : SCORE_W'(expected_matches(cx, cy));
    shown       = (frame_ends % DISPLAY_DIV) == 0;
    com_i.x     = pose_pkg::coord_w_x'(cx);
    com_i.y     = pose_pkg::coord_w_y'(cy);
    com_valid_i = 1'b1;
    next_cycle();
    com_valid_i = 1'b0;
    for (int p = 0; p < NPIX; p++) begin
      check_quiet();
      if (gap_pct > 0 && int'($urandom % 100) < gap_pct) begin
        repeat (1 + $urandom % 3) begin
          beat_i = '0;
          next_cycle();
          check_quiet();
        end
      end
      beat_i.valid  = 1'b1;
      beat_i.hcount = pose_pkg::coord_w_x'(p % FRAME_W);
      beat_i.vcount = pose_pkg::coord_w_y'(p / FRAME_W);
      beat_i.pixel  = cur_pix[p];
      next_cycle();
    end
    beat_i = '0;
    // i counts edges past the one that took the last beat, pulse due on the third
    for (int i = 0; i < 4; i++) begin
      if (i > 0) next_cycle();
      compare_ack("capture_ack_o", capture_ack_o, store);
      compare_valid("score_valid_o", score_valid_o, shown && i == 2);
      if (shown && i == 2) compare_score("score_o", score_o, exp_score);
    end
    frame_ends++;
    if (shown) held_score = exp_score;
    if (store) begin
      ref_pix = cur_pix;
      ref_x   = cx;
      ref_y   = cy;
      ref_ok  = 1'b1;
    end
  endtask

  // filler frames until the next frame end is a displayed one
  task automatic align_display(input int cx, input int cy);
    while (frame_ends % DISPLAY_DIV != 0) send_frame(cx, cy, 1'b0);
  endtask

  task automatic test_reset_state();
    check_quiet();
    fill_random();
    send_frame(8, 4, 1'b0);  // shown, but no reference so 0
  endtask

  task automatic test_capture_handshake(input int cx, input int cy);
    fill_random();
    capture_req_i = 1'b1;
    next_cycle();
    send_frame(cx, cy, 1'b1);  // ack low through the frame, high after its last beat
    repeat (2) begin
      next_cycle();
      compare_ack("capture_ack_o", capture_ack_o, 1'b1);  // held while req stays up
    end
    capture_req_i = 1'b0;
    next_cycle();
    compare_ack("capture_ack_o", capture_ack_o, 1'b0);
  endtask

  task automatic test_same_com();
    int ones;
    ones = 0;
    for (int p = 0; p < NPIX; p++) begin
      cur_pix[p] = ref_pix[p];
      ones += int'(ref_pix[p]);
    end
    align_display(ref_x, ref_y);
    send_frame(ref_x, ref_y, 1'b0);
    compare_score("score_o", score_o, SCORE_W'(ones));  // every set pixel finds itself
  endtask

  task automatic test_shifted_com();
    fill_random();
    align_display(11, 2);
    send_frame(11, 2, 1'b0);
    align_display(0, 0);
    send_frame(0, 0, 1'b0);      // left and top edges clamp
    align_display(15, 7);
    send_frame(15, 7, 1'b0);     // right and bottom edges clamp
    align_display(300, 170);
    send_frame(300, 170, 1'b0);  // all pixels pile onto the far corner
  endtask

  task automatic test_decimation();
    int first;
    align_display(ref_x, ref_y);
    first = pulses;
    for (int f = 1; f <= 7; f++) begin
      fill_random();
      send_frame(ref_x + f % 3, ref_y - 1, 1'b0);  // shown on 1, 4 and 7
    end
    if (pulses - first != 3) fail_run("seven frames did not give exactly three score pulses");
  endtask

  task automatic test_random_gaps();
    int cx;
    int cy;
    gap_pct = 30;
    test_capture_handshake($urandom % FRAME_W, $urandom % FRAME_H);  // new reference
    repeat (4) begin
      fill_random();
      cx = $urandom % FRAME_W;
      cy = $urandom % FRAME_H;
      align_display(cx, cy);
      send_frame(cx, cy, 1'b0);
    end
    gap_pct = 0;
  endtask

  initial begin
    rnd           = $urandom(32'hdce9_f0f0);
    sys_rst_pixel = 1'b1;
    beat_i        = '0;
    com_i         = '0;
    com_valid_i   = 1'b0;
    capture_req_i = 1'b0;
    ref_ok        = 1'b0;
    ref_x         = 0;
    ref_y         = 0;
    frame_ends    = 0;
    gap_pct       = 0;
    held_score    = '0;
    repeat (3) @(posedge clk_pixel);
    #1;
    sys_rst_pixel = 1'b0;
    test_reset_state();
    test_capture_handshake(8, 4);
    test_same_com();
    test_shifted_com();
    test_decimation();
    test_random_gaps();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- pose_scorer.f
hw/pose_pkg.sv
hw/reference_ctrl.sv
hw/com_align.sv
hw/reference_buffer.sv
hw/match_accumulator.sv
hw/score_decimator.sv
hw/pose_scorer.sv
verification/tb_pose_scorer.sv

//--- run_sim.sh
#!/bin/sh
# build tb_pose_scorer with Verilator, run it, then look for the fail line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pose_scorer \
  -f pose_scorer.f -o sim_pose_scorer > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_pose_scorer > sim.log 2>&1 || echo "Result: FAILED" >> sim.log
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0
